// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef logic [15:0] word_t;   // data, address and instruction word
    typedef logic [1:0]  regIdx_t; // one of four registers
    typedef logic [3:0]  opcode_t;

    // opcodes, instr[15:12]
    localparam opcode_t opBne = 4'd0;
    localparam opcode_t opBeq = 4'd1;
    localparam opcode_t opAdi = 4'd4;
    localparam opcode_t opLwd = 4'd7;
    localparam opcode_t opSwd = 4'd8;
    localparam opcode_t opJmp = 4'd9;
    localparam opcode_t opR   = 4'd15;

    // R-type func field, instr[5:0]
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr
    } aluOp_e;

    // next PC source decided in ID
    typedef enum logic [1:0] {
        pcNext,
        pcBranch, // taken only if the compare agrees
        pcJump
    } pcSel_e;

    typedef enum logic [1:0] {
        fwdNone,
        fwdExMem,
        fwdMemWb
    } fwdSel_e;

endpackage

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cpuPkg::*; (
    input  word_t  idInstr,
    output pcSel_e pcSel,
    output logic   regWrite,
    output logic   aluSrcImm,
    output aluOp_e aluOp,
    output logic   memRead,
    output logic   memWrite,
    output logic   memToReg,
    output logic   isBranch,
    output logic   isWwd,
    output logic   isHalt
);

    opcode_t    opcode;
    logic [5:0] func;

    assign opcode = idInstr[15:12];
    assign func   = idInstr[5:0];

    always_comb begin
        // anything not listed below falls through as a nop
        pcSel     = pcNext;
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        aluOp     = aluAdd;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        isBranch  = 1'b0;
        isWwd     = 1'b0;
        isHalt    = 1'b0;
        case (opcode)
            opR: begin
                case (func)
                    fnAdd: regWrite = 1'b1;
                    fnSub: begin
                        regWrite = 1'b1;
                        aluOp    = aluSub;
                    end
                    fnAnd: begin
                        regWrite = 1'b1;
                        aluOp    = aluAnd;
                    end
                    fnOrr: begin
                        regWrite = 1'b1;
                        aluOp    = aluOr;
                    end
                    fnWwd: isWwd  = 1'b1; // rs value rides down to WB
                    fnHlt: isHalt = 1'b1;
                    default: ;
                endcase
            end
            opAdi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opLwd: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1; // address is rs + imm
                memRead   = 1'b1;
                memToReg  = 1'b1;
            end
            opSwd: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            opBne, opBeq: begin
                isBranch = 1'b1;
                pcSel    = pcBranch;
            end
            opJmp: pcSel = pcJump;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t rs,
    input  regIdx_t rt,
    input  regIdx_t wAddr,
    input  word_t   wData,
    input  logic    wEnable,
    output word_t   rData1,
    output word_t   rData2
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wEnable) begin
            regs[wAddr] <= wData;
        end
    end

    // write-through, so a reader in ID sees the WB value in the same cycle
    assign rData1 = (wEnable && wAddr == rs) ? wData : regs[rs];
    assign rData2 = (wEnable && wAddr == rt) ? wData : regs[rt];

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_e op,
    output word_t  result
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b; // wraps at 16 bits
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
    input  regIdx_t idRs,
    input  regIdx_t idRt,
    input  regIdx_t exRs,
    input  regIdx_t exRt,
    input  regIdx_t exRd,
    input  regIdx_t memRd,
    input  regIdx_t wbRd,
    input  logic    exRegWrite,
    input  logic    exMemRead,
    input  logic    memRegWrite,
    input  logic    wbRegWrite,
    input  logic    branchTaken,
    input  pcSel_e  pcSel,
    output fwdSel_e idFwdA,
    output fwdSel_e idFwdB,
    output fwdSel_e exFwdA,
    output fwdSel_e exFwdB,
    output logic    stall,
    output logic    flush
);

    logic exHitsId;
    logic loadUse;
    logic branchUse;

    function automatic logic hits(regIdx_t src, regIdx_t dst, logic dstWrite);
        return dstWrite && (src == dst);
    endfunction

    // EX/MEM is younger, so it wins over MEM/WB
    assign idFwdA = hits(idRs, memRd, memRegWrite) ? fwdExMem :
                    hits(idRs, wbRd, wbRegWrite)   ? fwdMemWb : fwdNone;
    assign idFwdB = hits(idRt, memRd, memRegWrite) ? fwdExMem :
                    hits(idRt, wbRd, wbRegWrite)   ? fwdMemWb : fwdNone;
    assign exFwdA = hits(exRs, memRd, memRegWrite) ? fwdExMem :
                    hits(exRs, wbRd, wbRegWrite)   ? fwdMemWb : fwdNone;
    assign exFwdB = hits(exRt, memRd, memRegWrite) ? fwdExMem :
                    hits(exRt, wbRd, wbRegWrite)   ? fwdMemWb : fwdNone;

    // ID fields are matched whether or not the instruction reads them
    assign exHitsId = (exRd == idRs) || (exRd == idRt);

    assign loadUse   = exMemRead && exHitsId;
    // branch compares in ID, so an EX result is one cycle too late
    assign branchUse = (pcSel == pcBranch) && exRegWrite && exHitsId;

    assign stall = loadUse || branchUse;
    assign flush = !stall && (branchTaken || pcSel == pcJump);

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  word_t   instr,
    input  word_t   dmemRdata,
    input  pcSel_e  pcSel,
    input  logic    regWrite,
    input  logic    aluSrcImm,
    input  aluOp_e  aluOp,
    input  logic    memRead,
    input  logic    memWrite,
    input  logic    memToReg,
    input  logic    isBranch,
    input  logic    isWwd,
    input  logic    isHalt,
    input  fwdSel_e idFwdA,
    input  fwdSel_e idFwdB,
    input  fwdSel_e exFwdA,
    input  fwdSel_e exFwdB,
    input  logic    stall,
    input  logic    flush,
    output logic    imemRead,
    output word_t   imemAddr,
    output logic    dmemRead,
    output logic    dmemWrite,
    output word_t   dmemAddr,
    output word_t   dmemWdata,
    output word_t   idInstr,
    output regIdx_t idRs,
    output regIdx_t idRt,
    output regIdx_t exRs,
    output regIdx_t exRt,
    output regIdx_t exRd,
    output regIdx_t memRd,
    output regIdx_t wbRd,
    output logic    exRegWrite,
    output logic    exMemRead,
    output logic    memRegWrite,
    output logic    wbRegWrite,
    output logic    branchTaken,
    output word_t   outputPort,
    output logic    outputValid,
    output word_t   numInst,
    output logic    isHalted
);

    localparam word_t nopInstr = {4'd2, 12'd0}; // opcode 2 is unassigned

    word_t   pc, idPc, ifIdInstr;
    logic    idValid, fetchStop;
    word_t   idImm, rfData1, rfData2, idOpA, idOpB;
    word_t   branchTarget, jumpTarget, redirect;
    regIdx_t idDest;

    logic    exValid, exMemWrite, exMemToReg, exAluSrcImm, exIsWwd, exIsHalt;
    aluOp_e  exAluOp;
    word_t   exRsVal, exRtVal, exImm, exOpA, exOpB, aluB, aluResult;

    logic    memValid, memMemRead, memMemWrite, memMemToReg, memIsWwd, memIsHalt;
    word_t   memAluResult, memStoreData, memRsVal, memValue;

    logic    wbValid, wbMemToReg, wbIsWwd, wbIsHalt;
    word_t   wbAluResult, wbMemData, wbRsVal, wbValue, lastOutput;

    function automatic word_t fwdMux(fwdSel_e sel, word_t base, word_t fromMem,
                                     word_t fromWb);
        case (sel)
            fwdExMem: return fromMem;
            fwdMemWb: return fromWb;
            default:  return base;
        endcase
    endfunction

    // IF
    assign imemRead = !fetchStop;
    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            idValid   <= 1'b0;
            fetchStop <= 1'b0;
        end else begin
            if (!stall && !fetchStop) pc <= flush ? redirect : pc + 16'd1;
            if (!stall) idValid <= imemRead && !flush && !isHalt; // kill the slot after HLT
            if (isHalt) fetchStop <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdInstr <= instr;
            idPc      <= pc;
        end
    end

    // ID
    assign idInstr = idValid ? ifIdInstr : nopInstr;
    assign idRs    = idInstr[11:10];
    assign idRt    = idInstr[9:8];
    assign idDest  = aluSrcImm ? idInstr[9:8] : idInstr[7:6]; // I-type writes rt
    assign idImm   = {{8{idInstr[7]}}, idInstr[7:0]};

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .rs(idRs),
        .rt(idRt),
        .wAddr(wbRd),
        .wData(wbValue),
        .wEnable(wbRegWrite),
        .rData1(rfData1),
        .rData2(rfData2)
    );

    assign idOpA = fwdMux(idFwdA, rfData1, memValue, wbValue);
    assign idOpB = fwdMux(idFwdB, rfData2, memValue, wbValue);

    // BEQ wants equal, BNE wants different
    assign branchTaken  = isBranch && ((idOpA == idOpB) == (idInstr[15:12] == opBeq));
    assign branchTarget = idPc + 16'd1 + idImm;
    assign jumpTarget   = {idPc[15:12], idInstr[11:0]};
    assign redirect     = (pcSel == pcJump) ? jumpTarget : branchTarget;

    always_ff @(posedge clk) begin
        if (reset || stall) begin // a stall leaves a bubble in EX
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exMemToReg <= 1'b0;
            exIsWwd    <= 1'b0;
            exIsHalt   <= 1'b0;
        end else begin
            exValid    <= idValid;
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exMemToReg <= memToReg;
            exIsWwd    <= isWwd;
            exIsHalt   <= isHalt;
        end
    end

    always_ff @(posedge clk) begin
        exRs        <= idRs;
        exRt        <= idRt;
        exRd        <= idDest;
        exRsVal     <= idOpA;
        exRtVal     <= idOpB;
        exImm       <= idImm;
        exAluSrcImm <= aluSrcImm;
        exAluOp     <= aluOp;
    end

    // EX
    assign exOpA = fwdMux(exFwdA, exRsVal, memValue, wbValue);
    assign exOpB = fwdMux(exFwdB, exRtVal, memValue, wbValue); // also the store data
    assign aluB  = exAluSrcImm ? exImm : exOpB;

    aluUnit alu (
        .a(exOpA),
        .b(aluB),
        .op(exAluOp),
        .result(aluResult)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memMemToReg <= 1'b0;
            memIsWwd    <= 1'b0;
            memIsHalt   <= 1'b0;
        end else begin
            memValid    <= exValid;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memMemToReg <= exMemToReg;
            memIsWwd    <= exIsWwd;
            memIsHalt   <= exIsHalt;
        end
    end

    always_ff @(posedge clk) begin
        memRd        <= exRd;
        memAluResult <= aluResult;
        memStoreData <= exOpB;
        memRsVal     <= exOpA;
    end

    // MEM, memory answers in the same cycle
    assign dmemRead  = memMemRead;
    assign dmemWrite = memMemWrite;
    assign dmemAddr  = memAluResult;
    assign dmemWdata = memStoreData;
    assign memValue  = memMemToReg ? dmemRdata : memAluResult; // load data forwards too

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
            wbIsWwd    <= 1'b0;
            wbIsHalt   <= 1'b0;
        end else begin
            wbValid    <= memValid;
            wbRegWrite <= memRegWrite;
            wbMemToReg <= memMemToReg;
            wbIsWwd    <= memIsWwd;
            wbIsHalt   <= memIsHalt;
        end
    end

    always_ff @(posedge clk) begin
        wbRd        <= memRd;
        wbAluResult <= memAluResult;
        wbMemData   <= dmemRdata;
        wbRsVal     <= memRsVal;
    end

    // WB
    assign wbValue     = wbMemToReg ? wbMemData : wbAluResult;
    assign outputValid = wbValid && wbIsWwd;
    assign outputPort  = outputValid ? wbRsVal : lastOutput;

    always_ff @(posedge clk) begin
        if (reset) begin
            numInst    <= '0;
            isHalted   <= 1'b0;
            lastOutput <= '0;
        end else begin
            if (wbValid) numInst <= numInst + 16'd1; // bubbles never count
            if (wbValid && wbIsHalt) isHalted <= 1'b1;
            if (outputValid) lastOutput <= wbRsVal;
        end
    end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  logic  clk,
    input  logic  reset,
    output logic  imemRead,
    output word_t imemAddr,
    input  word_t instr,
    output logic  dmemRead,
    output logic  dmemWrite,
    output word_t dmemAddr,
    output word_t dmemWdata,
    input  word_t dmemRdata,
    output word_t outputPort,
    output logic  outputValid,
    output word_t numInst,
    output logic  isHalted
);

    // decode levels for the instruction in ID
    pcSel_e  pcSel;
    aluOp_e  aluOp;
    logic    regWrite, aluSrcImm, memRead, memWrite, memToReg;
    logic    isBranch, isWwd, isHalt;

    // hazard and forwarding
    word_t   idInstr;
    regIdx_t idRs, idRt, exRs, exRt, exRd, memRd, wbRd;
    logic    exRegWrite, exMemRead, memRegWrite, wbRegWrite, branchTaken;
    fwdSel_e idFwdA, idFwdB, exFwdA, exFwdB;
    logic    stall, flush;

    datapath dpath (.*);

    controlUnit ctrl (.*);

    hazardUnit hazard (.*);

endmodule

`default_nettype wire

// ==== cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        dmemRead,
    input wire logic        dmemWrite,
    input wire logic        outputValid,
    input wire logic        isHalted,
    input wire logic [15:0] numInst
);

    noReadWrite: assert property (@(posedge clk) !(dmemRead && dmemWrite))
        else $error("dmemRead and dmemWrite high together");

    // wb regs clear one edge into reset
    quietInReset: assert property (@(posedge clk) reset && $past(reset) |-> !outputValid)
        else $error("outputValid high during reset");

    haltSticks: assert property (@(posedge clk) disable iff (reset) isHalted |=> isHalted)
        else $error("isHalted dropped without reset");

    countRises: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> numInst >= $past(numInst))
        else $error("numInst decreased");

endmodule

bind cpuTop cpu_checker chk (.*);

`default_nettype wire

// ==== cpuMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuMonitor (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        imemRead,
    input wire logic        outputValid,
    input wire logic [15:0] outputPort,
    input wire logic [15:0] numInst
);

    string       testName;
    bit          active;
    int          testErrors;
    int          outIdx;
    int          expCount;
    int          passCount;
    int          failCount;
    logic [15:0] expOut [$];
    logic [15:0] expMem [256];

    // ISA interpreter over the testbench memories until HLT
    function automatic void runModel();
        logic [15:0] r [4];
        logic [15:0] pc, ins, imm, addr, nextPc;
        logic [1:0]  rs, rt, rd;
        bit          halted;
        int          steps;
        for (int i = 0; i < 4; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) expMem[i] = tb_cpu.dmem[i];
        expOut.delete();
        expCount = 0;
        pc = '0;
        halted = 0;
        steps = 0;
        while (!halted && steps < 1000) begin
            ins = tb_cpu.imem[pc[7:0]];
            rs = ins[11:10];
            rt = ins[9:8];
            rd = ins[7:6];
            imm = {{8{ins[7]}}, ins[7:0]};
            addr = r[rs] + imm;
            nextPc = pc + 16'd1;
            case (ins[15:12])
                4'd15: begin
                    case (ins[5:0])
                        6'd0:  r[rd] = r[rs] + r[rt];
                        6'd1:  r[rd] = r[rs] - r[rt];
                        6'd2:  r[rd] = r[rs] & r[rt];
                        6'd3:  r[rd] = r[rs] | r[rt];
                        6'd28: expOut.push_back(r[rs]);
                        6'd29: halted = 1;
                        default: ;
                    endcase
                end
                4'd4: r[rt] = addr;                    // ADI adds rs and imm
                4'd7: r[rt] = expMem[addr[7:0]];
                4'd8: expMem[addr[7:0]] = r[rt];
                4'd0: if (r[rs] != r[rt]) nextPc = pc + 16'd1 + imm;
                4'd1: if (r[rs] == r[rt]) nextPc = pc + 16'd1 + imm;
                4'd9: nextPc = {pc[15:12], ins[11:0]};
                default: ;                             // unused opcodes act as nop
            endcase
            expCount++;
            steps++;
            pc = nextPc;
        end
    endfunction

    task automatic checkWord(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %h actual %h", testName, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
        outIdx = 0;
        runModel();
        active = 1;
    endtask

    task automatic endTest(input bit halted);
        int          memErrors;
        logic [15:0] lastExp;
        active = 0;
        memErrors = 0;
        if (!halted) begin
            $display("FAIL %s: the cpu never halted within 200 cycles", testName);
            testErrors++;
        end else begin
            if (outIdx != expOut.size()) begin
                $display("FAIL %s: WWD count expected %0d actual %0d", testName,
                         expOut.size(), outIdx);
                testErrors++;
            end
            checkWord("numInst", expCount[15:0], numInst);
            checkWord("imemRead after halt", 16'd0, {15'd0, imemRead});
            // last WWD value stays on the port
            lastExp = (expOut.size() > 0) ? expOut[expOut.size() - 1] : 16'd0;
            checkWord("outputPort after halt", lastExp, outputPort);
            for (int i = 0; i < 256; i++) begin
                if (tb_cpu.dmem[i] !== expMem[i] && memErrors < 4) begin
                    $display("FAIL %s: dmem[%0d] expected %h actual %h", testName, i,
                             expMem[i], tb_cpu.dmem[i]);
                    memErrors++;
                end
            end
            testErrors += memErrors;
        end
        if (testErrors == 0) begin
            $display("PASS %s", testName);
            passCount++;
        end else begin
            $display("FAIL %s with %0d errors", testName, testErrors);
            failCount++;
        end
    endtask

    // each WWD pulse against the next expected value
    always @(posedge clk) begin
        if (active && !reset && outputValid) begin
            if (outIdx >= expOut.size()) begin
                $display("FAIL %s: unexpected WWD output %h after the last one", testName,
                         outputPort);
                testErrors++;
            end else begin
                checkWord($sformatf("WWD #%0d", outIdx), expOut[outIdx], outputPort);
            end
            outIdx++;
        end
    end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam logic [5:0] fAdd = 6'd0, fSub = 6'd1, fAnd = 6'd2, fOrr = 6'd3;
    localparam logic [5:0] fWwd = 6'd28, fHlt = 6'd29;

    logic        clk, reset;
    logic        imemRead, dmemRead, dmemWrite, outputValid, isHalted;
    logic [15:0] imemAddr, instr, dmemAddr, dmemWdata, dmemRdata, outputPort, numInst;
    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] rnd [8];
    int          seed;
    int          ptr;

    assign instr     = imem[imemAddr[7:0]];
    assign dmemRdata = dmem[dmemAddr[7:0]];

    always @(posedge clk) begin
        if (dmemWrite) dmem[dmemAddr[7:0]] <= dmemWdata;
    end

    always #4 clk = ~clk;

    cpuTop u_dut (.*);

    cpuMonitor mon (
        .clk(clk),
        .reset(reset),
        .imemRead(imemRead),
        .outputValid(outputValid),
        .outputPort(outputPort),
        .numInst(numInst)
    );

    function automatic logic [15:0] encR(input logic [1:0] rs, rt, rd, input logic [5:0] fn);
        return {4'hF, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encI(input logic [3:0] op, input logic [1:0] rs, rt,
                                         input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [15:0] w);
        imem[ptr] = w;
        ptr++;
    endtask

    task automatic loadProgram(input int which);
        for (int i = 0; i < 256; i++) begin
            imem[i] = {8'h20, i[7:0]};     // opcode 2 decodes as a nop
            dmem[i] = {i[7:0], ~i[7:0]};
        end
        ptr = 0;
        case (which)
            1: begin                        // ALU chain on loaded random words
                for (int i = 0; i < 3; i++) begin
                    dmem[i] = rnd[i];
                    emit(encI(4'd7, 2'd3, i[1:0], i[7:0]));
                end
                emit(encR(0, 1, 2, fAdd));
                emit(encR(2, 0, 1, fSub));
                emit(encR(1, 2, 0, fAnd));
                emit(encR(0, 1, 3, fOrr));
                emit(encR(3, 0, 0, fWwd));
                emit(encR(2, 0, 0, fWwd));
                emit(encR(1, 0, 0, fWwd));
                emit(encR(0, 0, 0, fWwd));
                emit(encR(0, 0, 0, fHlt));
            end
            2: begin                        // immediates with wrap
                emit(encI(4'd4, 3, 0, 8'h7F));
                emit(encI(4'd4, 0, 1, 8'h80));
                emit(encI(4'd4, 1, 2, 8'h05));
                emit(encI(4'd4, 2, 3, 8'hFD));
                emit(encI(4'd4, 3, 3, rnd[0][7:0]));
                for (int i = 0; i < 4; i++) emit(encR(i[1:0], 0, 0, fWwd));
                emit(encR(0, 0, 0, fHlt));
            end
            3: begin                        // stores, loads, load-use stalls
                dmem[(rnd[1][5:0] + rnd[5][5:0]) & 8'hFF] = rnd[6];
                emit(encI(4'd4, 3, 0, {2'b00, rnd[1][5:0]}));
                emit(encI(4'd4, 3, 1, rnd[2][7:0]));
                emit(encI(4'd8, 0, 1, {2'b00, rnd[3][5:0]}));
                emit(encI(4'd7, 0, 2, {2'b00, rnd[3][5:0]}));
                emit(encR(2, 1, 3, fAdd));
                emit(encR(3, 0, 0, fWwd));
                emit(encI(4'd8, 0, 3, {2'b00, rnd[4][5:0]}));
                emit(encI(4'd7, 0, 1, {2'b00, rnd[5][5:0]}));
                emit(encR(1, 0, 0, fWwd));
                emit(encI(4'd7, 0, 2, {2'b00, rnd[4][5:0]}));
                emit(encR(2, 1, 0, fSub));
                emit(encR(0, 0, 0, fWwd));
                emit(encR(0, 0, 0, fHlt));
            end
            4: begin                        // branches and a jump
                emit(encI(4'd4, 3, 0, 8'd5));
                emit(encI(4'd4, 3, 1, 8'd5));
                emit(encI(4'd1, 0, 1, 8'd1));   // taken and needs r1 from EX
                emit(encR(0, 0, 0, fWwd));
                emit(encI(4'd0, 0, 1, 8'd1));   // not taken
                emit(encR(1, 0, 0, fWwd));
                emit(encI(4'd4, 0, 2, 8'd1));
                emit(encI(4'd0, 2, 0, 8'd1));   // taken
                emit(encR(2, 0, 0, fWwd));
                emit(encI(4'd1, 2, 0, 8'd1));   // not taken
                emit(encR(2, 0, 0, fWwd));
                emit({4'h9, 12'd13});
                emit(encR(0, 0, 0, fWwd));      // jumped over
                emit(encI(4'd4, 3, 3, 8'hFF));
                emit(encR(3, 0, 0, fWwd));
                emit(encR(0, 0, 0, fHlt));
            end
            default: begin                  // code past HLT must stay dead
                emit(encI(4'd4, 3, 0, 8'd9));
                emit(encI(4'd8, 3, 0, 8'h10));
                emit(encR(0, 0, 0, fWwd));
                emit(encR(0, 0, 0, fHlt));
                emit(encI(4'd4, 3, 0, 8'd1));
                emit(encR(0, 0, 0, fWwd));
                emit(encI(4'd8, 3, 0, 8'h11));
                emit(encR(0, 0, 0, fHlt));
            end
        endcase
    endtask

    // returns 1 ns after the fifth edge with reset still high
    task automatic applyReset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
    endtask

    task automatic runTest(input string name, input int which);
        bit halted;
        applyReset();
        loadProgram(which);
        mon.beginTest(name);
        mon.checkWord("numInst in reset", 16'd0, numInst);
        reset = 1'b0;
        halted = 0;
        for (int c = 0; c < 200 && !halted; c++) begin
            @(posedge clk);
            #1 halted = isHalted;
        end
        if (halted) begin
            repeat (5) @(posedge clk);     // nothing may move after halt
            #1;
        end
        mon.endTest(halted);
    endtask

    initial begin
        #(6 * 210 * 8);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        seed = 32'h445f4e77;
        for (int i = 0; i < 8; i++) rnd[i] = $random(seed);
        runTest("alu_forwarding", 1);
        runTest("immediates", 2);
        runTest("load_store", 3);
        runTest("branch_jump", 4);
        runTest("halt_retire", 5);
        applyReset();
        loadProgram(3);
        reset = 1'b0;
        repeat (9) @(posedge clk);         // stop partway through and start over
        runTest("reset_midway", 3);
        $display("tests passed %0d, failed %0d", mon.passCount, mon.failCount);
        if (mon.failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
cpuPkg.sv
controlUnit.sv
registerFile.sv
aluUnit.sv
hazardUnit.sv
datapath.sv
cpuTop.sv
cpu_checker.sv
cpuMonitor.sv
tb_cpu.sv
